// ==== src/eth_pkg.sv ====
// Shared widths, flag codes, pause constants and the txc control word for the 10G bridge
`default_nettype none

package eth_pkg;

   // Stream widths
   localparam int data_w      = 64;                // DMA and MAC data
   localparam int keep_w      = data_w / 8;
   localparam int ctrl_w      = 32;                // txc and rxs words
   localparam int ctrl_keep_w = ctrl_w / 8;

   // Flag nibbles
   localparam logic [3:0] txc_flag_normal = 4'hA; // Normal transmit control packet
   localparam logic [3:0] rxs_flag_status = 4'h5; // Top nibble of status word 0

   // MAC control pause frame
   localparam logic [15:0] pause_ethertype = 16'h8808;
   localparam logic [15:0] pause_opcode    = 16'h0001;

   // Transmit framer states
   localparam logic [1:0] tx_st_ctrl0 = 2'd0;     // Expect control word 0
   localparam logic [1:0] tx_st_ctrl1 = 2'd1;     // Expect control word 1
   localparam logic [1:0] tx_st_data  = 2'd2;     // Forward txd frame

   // Word 0 carries the flag
   typedef struct packed {
      logic [3:0]        flag;
      logic [ctrl_w-5:0] rsvd;
   } txc_flag_view_t;

   // Word 1 carries the application field
   typedef struct packed {
      logic [ctrl_w-2:0] rsvd;
      logic              abort;                    // Drop request from software
   } txc_app_view_t;

   // Same txc beat, decoded by position in the control packet
   typedef union packed {
      txc_flag_view_t flag_view;
      txc_app_view_t  app_view;
   } txc_word_u;

endpackage

`default_nettype wire

// ==== src/eth_tx_framer.sv ====
// Transmit framer: consumes the txc control packet, then forwards the txd frame to the MAC
`timescale 1ns/100ps
`default_nettype none

module eth_tx_framer (
   input  wire                              mm2s_clk,
   input  wire                              rst_n,
   input  wire  [eth_pkg::ctrl_w-1:0]       txc_tdata,
   input  wire  [eth_pkg::ctrl_keep_w-1:0]  txc_tkeep,
   input  wire                              txc_tlast,
   input  wire                              txc_tvalid,
   output logic                             txc_tready,
   input  wire  [eth_pkg::data_w-1:0]       txd_tdata,
   input  wire  [eth_pkg::keep_w-1:0]       txd_tkeep,
   input  wire                              txd_tlast,
   input  wire                              txd_tvalid,
   output logic                             txd_tready,
   output logic [eth_pkg::data_w-1:0]       tx_axis_mac_tdata,
   output logic [eth_pkg::keep_w-1:0]       tx_axis_mac_tkeep,
   output logic                             tx_axis_mac_tlast,
   output logic                             tx_axis_mac_tuser,
   output logic                             tx_axis_mac_tvalid,
   input  wire                              tx_axis_mac_tready
);

   logic [1:0]         state;
   logic               bad_frame;     // Frame goes out with tuser on its last beat
   logic               txc_fire;
   logic               txd_fire;
   logic               ctrl_partial;  // Word without full keep
   eth_pkg::txc_word_u txc_word;

   assign txc_word     = txc_tdata;
   assign ctrl_partial = (txc_tkeep != {eth_pkg::ctrl_keep_w{1'b1}});

   // Control accepted one word per cycle until the data phase
   assign txc_tready = (state != eth_pkg::tx_st_data);
   assign txc_fire   = txc_tvalid && txc_tready;

   // Data only while the output stage is empty or draining
   assign txd_tready = (state == eth_pkg::tx_st_data) &&
                       (!tx_axis_mac_tvalid || tx_axis_mac_tready);
   assign txd_fire   = txd_tvalid && txd_tready;

   always_ff @(posedge mm2s_clk)
   begin
      if (!rst_n)
      begin
         state     <= eth_pkg::tx_st_ctrl0;
         bad_frame <= 1'b0;
      end
      else
      begin
         case (state)
            eth_pkg::tx_st_ctrl0:
               if (txc_fire)
               begin
                  // Flag check, short packet counts as malformed
                  bad_frame <= (txc_word.flag_view.flag != eth_pkg::txc_flag_normal) ||
                               ctrl_partial || txc_tlast;
                  state     <= txc_tlast ? eth_pkg::tx_st_data : eth_pkg::tx_st_ctrl1;
               end
            eth_pkg::tx_st_ctrl1:
               if (txc_fire)
               begin
                  bad_frame <= bad_frame || txc_word.app_view.abort || ctrl_partial;
                  state     <= eth_pkg::tx_st_data;
               end
            eth_pkg::tx_st_data:
               if (txd_fire && txd_tlast)
                  state <= eth_pkg::tx_st_ctrl0;   // Next control packet
            default:
               state <= eth_pkg::tx_st_ctrl0;
         endcase
      end
   end

   // Output stage valid
   always_ff @(posedge mm2s_clk)
   begin
      if (!rst_n)
         tx_axis_mac_tvalid <= 1'b0;
      else if (txd_fire)
         tx_axis_mac_tvalid <= 1'b1;
      else if (tx_axis_mac_tready)
         tx_axis_mac_tvalid <= 1'b0;               // Drained
   end

   // Output stage payload, loads only on a txd transfer
   always_ff @(posedge mm2s_clk)
   begin
      if (txd_fire)
      begin
         tx_axis_mac_tdata <= txd_tdata;
         tx_axis_mac_tkeep <= txd_tkeep;
         tx_axis_mac_tlast <= txd_tlast;
         tx_axis_mac_tuser <= txd_tlast && bad_frame;   // Error only on last beat
      end
   end

endmodule

`default_nettype wire

// ==== src/eth_rx_payload.sv ====
// Receive forwarder: registers MAC beats onto rxd, counts frame bytes and reports frame end
`timescale 1ns/100ps
`default_nettype none

module eth_rx_payload (
   input  wire                          mm2s_clk,
   input  wire                          rst_n,
   input  wire  [eth_pkg::data_w-1:0]   rx_axis_mac_tdata,
   input  wire  [eth_pkg::keep_w-1:0]   rx_axis_mac_tkeep,
   input  wire                          rx_axis_mac_tlast,
   input  wire                          rx_axis_mac_tuser,
   input  wire                          rx_axis_mac_tvalid,
   output logic                         rx_axis_mac_tready,
   output logic [eth_pkg::data_w-1:0]   rxd_tdata,
   output logic [eth_pkg::keep_w-1:0]   rxd_tkeep,
   output logic                         rxd_tlast,
   output logic                         rxd_tvalid,
   input  wire                          rxd_tready,
   input  wire                          status_busy,
   output logic                         beat_fire,
   output logic                         frame_done,
   output logic [15:0]                  byte_count,
   output logic                         frame_good
);

   logic [15:0] byte_acc;     // Bytes of earlier beats in this frame
   logic [15:0] beat_bytes;

   // Last beat waits for the status writer to free up
   assign rx_axis_mac_tready = (!rxd_tvalid || rxd_tready) &&
                               !(rx_axis_mac_tlast && status_busy);

   assign beat_fire  = rx_axis_mac_tvalid && rx_axis_mac_tready;
   assign frame_done = beat_fire && rx_axis_mac_tlast;

   // Running total including the current beat, valid at frame_done
   assign beat_bytes = 16'($countones(rx_axis_mac_tkeep));
   assign byte_count = byte_acc + beat_bytes;
   assign frame_good = rx_axis_mac_tuser;          // MAC good flag, sampled on last beat

   always_ff @(posedge mm2s_clk)
   begin
      if (!rst_n)
         byte_acc <= 16'd0;
      else if (frame_done)
         byte_acc <= 16'd0;                        // Restart for next frame
      else if (beat_fire)
         byte_acc <= byte_count;
   end

   // rxd stage valid
   always_ff @(posedge mm2s_clk)
   begin
      if (!rst_n)
         rxd_tvalid <= 1'b0;
      else if (beat_fire)
         rxd_tvalid <= 1'b1;
      else if (rxd_tready)
         rxd_tvalid <= 1'b0;
   end

   // rxd stage payload
   always_ff @(posedge mm2s_clk)
   begin
      if (beat_fire)
      begin
         rxd_tdata <= rx_axis_mac_tdata;
         rxd_tkeep <= rx_axis_mac_tkeep;
         rxd_tlast <= rx_axis_mac_tlast;
      end
   end

endmodule

`default_nettype wire

// ==== src/eth_pause_detect.sv ====
// Pause detector: checks the MAC control header of each received frame and raises pause requests
`timescale 1ns/100ps
`default_nettype none

module eth_pause_detect (
   input  wire                         mm2s_clk,
   input  wire                         rst_n,
   input  wire                         beat_fire,
   input  wire                         frame_done,
   input  wire  [eth_pkg::data_w-1:0]  rx_axis_mac_tdata,
   input  wire                         rx_axis_mac_tuser,
   output logic                        is_pause,
   output logic                        pause_req,
   output logic [15:0]                 pause_val
);

   logic [1:0]  beat_idx;     // Saturates at 3
   logic        hdr_match;    // Ethertype and opcode seen on beat 1
   logic        hdr_now;
   logic [15:0] quanta_now;
   logic [15:0] quanta_q;     // Quanta from beat 2
   logic        pause_hit;

   // Bytes 12..15 on lanes 4..7, network order
   assign hdr_now = ({rx_axis_mac_tdata[39:32], rx_axis_mac_tdata[47:40]} ==
                     eth_pkg::pause_ethertype) &&
                    ({rx_axis_mac_tdata[55:48], rx_axis_mac_tdata[63:56]} ==
                     eth_pkg::pause_opcode);

   assign quanta_now = {rx_axis_mac_tdata[7:0], rx_axis_mac_tdata[15:8]};   // Bytes 16, 17

   // Header must come from this frame, so beat 1 is already behind us
   assign is_pause  = hdr_match && (beat_idx >= 2'd2);
   assign pause_hit = frame_done && is_pause && rx_axis_mac_tuser;

   always_ff @(posedge mm2s_clk)
   begin
      if (!rst_n)
      begin
         beat_idx  <= 2'd0;
         hdr_match <= 1'b0;
         pause_req <= 1'b0;
         pause_val <= 16'd0;
      end
      else
      begin
         pause_req <= pause_hit;                   // One cycle after frame_done
         if (pause_hit)
            pause_val <= (beat_idx == 2'd2) ? quanta_now : quanta_q;   // Held until next hit
         if (beat_fire)
         begin
            if (frame_done)
               beat_idx <= 2'd0;
            else if (beat_idx != 2'd3)
               beat_idx <= beat_idx + 2'd1;
            if (beat_idx == 2'd1)
               hdr_match <= hdr_now;
         end
      end
   end

   always_ff @(posedge mm2s_clk)
   begin
      if (beat_fire && (beat_idx == 2'd2))
         quanta_q <= quanta_now;
   end

endmodule

`default_nettype wire

// ==== src/eth_rx_status.sv ====
// Receive status writer: latches per-frame results and sends the two-word rxs packet
`timescale 1ns/100ps
`default_nettype none

module eth_rx_status (
   input  wire                              mm2s_clk,
   input  wire                              rst_n,
   input  wire                              frame_done,
   input  wire  [15:0]                      byte_count,
   input  wire                              frame_good,
   input  wire                              is_pause,
   output logic [eth_pkg::ctrl_w-1:0]       rxs_tdata,
   output logic [eth_pkg::ctrl_keep_w-1:0]  rxs_tkeep,
   output logic                             rxs_tlast,
   output logic                             rxs_tvalid,
   input  wire                              rxs_tready,
   output logic                             status_busy
);

   logic        word_sel;     // 0 flag word, 1 result word
   logic [15:0] count_q;
   logic        good_q;
   logic        pause_q;

   assign status_busy = rxs_tvalid;                // Packet not fully sent
   assign rxs_tkeep   = {eth_pkg::ctrl_keep_w{1'b1}};
   assign rxs_tlast   = word_sel;

   assign rxs_tdata = word_sel ?
                      {{(eth_pkg::ctrl_w-18){1'b0}}, pause_q, good_q, count_q} :
                      {eth_pkg::rxs_flag_status, {(eth_pkg::ctrl_w-4){1'b0}}};

   always_ff @(posedge mm2s_clk)
   begin
      if (!rst_n)
      begin
         rxs_tvalid <= 1'b0;
         word_sel   <= 1'b0;
      end
      else if (frame_done)
      begin
         rxs_tvalid <= 1'b1;                       // Word 0 next cycle
         word_sel   <= 1'b0;
      end
      else if (rxs_tvalid && rxs_tready)
      begin
         rxs_tvalid <= !word_sel;                  // Done after word 1
         word_sel   <= !word_sel;
      end
   end

   // Frame results, captured once per frame
   always_ff @(posedge mm2s_clk)
   begin
      if (frame_done)
      begin
         count_q <= byte_count;
         good_q  <= frame_good;
         pause_q <= is_pause;
      end
   end

endmodule

`default_nettype wire

// ==== src/axi_10geth.sv ====
// 10G Ethernet DMA to MAC bridge top: transmit framer plus receive forwarder, pause and status
`timescale 1ns/100ps
`default_nettype none

module axi_10geth (
   input  wire                              mm2s_clk,
   input  wire                              rst_n,
   input  wire  [eth_pkg::ctrl_w-1:0]       txc_tdata,
   input  wire  [eth_pkg::ctrl_keep_w-1:0]  txc_tkeep,
   input  wire                              txc_tlast,
   input  wire                              txc_tvalid,
   output wire                              txc_tready,
   input  wire  [eth_pkg::data_w-1:0]       txd_tdata,
   input  wire  [eth_pkg::keep_w-1:0]       txd_tkeep,
   input  wire                              txd_tlast,
   input  wire                              txd_tvalid,
   output wire                              txd_tready,
   output wire  [eth_pkg::data_w-1:0]       tx_axis_mac_tdata,
   output wire  [eth_pkg::keep_w-1:0]       tx_axis_mac_tkeep,
   output wire                              tx_axis_mac_tlast,
   output wire                              tx_axis_mac_tuser,
   output wire                              tx_axis_mac_tvalid,
   input  wire                              tx_axis_mac_tready,
   input  wire  [eth_pkg::data_w-1:0]       rx_axis_mac_tdata,
   input  wire  [eth_pkg::keep_w-1:0]       rx_axis_mac_tkeep,
   input  wire                              rx_axis_mac_tlast,
   input  wire                              rx_axis_mac_tuser,
   input  wire                              rx_axis_mac_tvalid,
   output wire                              rx_axis_mac_tready,
   output wire  [eth_pkg::data_w-1:0]       rxd_tdata,
   output wire  [eth_pkg::keep_w-1:0]       rxd_tkeep,
   output wire                              rxd_tlast,
   output wire                              rxd_tvalid,
   input  wire                              rxd_tready,
   output wire  [eth_pkg::ctrl_w-1:0]       rxs_tdata,
   output wire  [eth_pkg::ctrl_keep_w-1:0]  rxs_tkeep,
   output wire                              rxs_tlast,
   output wire                              rxs_tvalid,
   input  wire                              rxs_tready,
   output wire                              pause_req,
   output wire  [15:0]                      pause_val
);

   // Receive side results between the forwarder, detector and status writer
   wire        beat_fire;
   wire        frame_done;
   wire [15:0] byte_count;
   wire        frame_good;
   wire        is_pause;
   wire        status_busy;     // Holds off the next last beat

   // Port names match the top level and the internal nets
   eth_tx_framer eth_tx_framer_inst (.*);

   eth_rx_payload eth_rx_payload_inst (.*);

   eth_pause_detect eth_pause_detect_inst (.*);

   eth_rx_status eth_rx_status_inst (.*);

endmodule

`default_nettype wire

// ==== tests/axi_10geth_sva.sv ====
// Stream protocol and reset assertions bound to the bridge top level
`timescale 1ns/100ps
`default_nettype none

module axi_10geth_sva (
   input wire        mm2s_clk,
   input wire        rst_n,
   input wire [63:0] tx_axis_mac_tdata,
   input wire        tx_axis_mac_tvalid,
   input wire        tx_axis_mac_tready,
   input wire [63:0] rxd_tdata,
   input wire        rxd_tvalid,
   input wire        rxd_tready,
   input wire [31:0] rxs_tdata,
   input wire        rxs_tvalid,
   input wire        rxs_tready,
   input wire        pause_req
);

   // Stalled beats hold valid and data
   a_tx_stall: assert property (@(posedge mm2s_clk) disable iff (!rst_n)
      tx_axis_mac_tvalid && !tx_axis_mac_tready |=> tx_axis_mac_tvalid && $stable(tx_axis_mac_tdata))
      else $error("tx_axis_mac changed while stalled");
   a_rxd_stall: assert property (@(posedge mm2s_clk) disable iff (!rst_n)
      rxd_tvalid && !rxd_tready |=> rxd_tvalid && $stable(rxd_tdata))
      else $error("rxd changed while stalled");
   a_rxs_stall: assert property (@(posedge mm2s_clk) disable iff (!rst_n)
      rxs_tvalid && !rxs_tready |=> rxs_tvalid && $stable(rxs_tdata))
      else $error("rxs changed while stalled");

   a_pause_pulse: assert property (@(posedge mm2s_clk) disable iff (!rst_n)
      pause_req |=> !pause_req)
      else $error("pause_req longer than one cycle");

   // Outputs idle one edge into reset
   a_reset_idle: assert property (@(posedge mm2s_clk)
      !rst_n |=> !tx_axis_mac_tvalid && !rxd_tvalid && !rxs_tvalid && !pause_req)
      else $error("valid or pause_req high after reset");

endmodule

bind axi_10geth axi_10geth_sva axi_10geth_sva_inst (.*);

`default_nettype wire

// ==== tests/tb_axi_10geth.sv ====
// Testbench for the 10G bridge that replays file records on both paths and checks every stream
`timescale 1ns/100ps
`default_nettype none

module tb_axi_10geth;

   logic mm2s_clk;
   logic rst_n;
   logic [31:0] txc_tdata;
   logic [3:0]  txc_tkeep;
   logic        txc_tlast;
   logic        txc_tvalid;
   logic [63:0] txd_tdata;
   logic [7:0]  txd_tkeep;
   logic        txd_tlast;
   logic        txd_tvalid;
   logic        tx_axis_mac_tready;
   logic [63:0] rx_axis_mac_tdata;
   logic [7:0]  rx_axis_mac_tkeep;
   logic        rx_axis_mac_tlast;
   logic        rx_axis_mac_tuser;
   logic        rx_axis_mac_tvalid;
   logic        rxd_tready;
   logic        rxs_tready;
   wire         txc_tready;
   wire         txd_tready;
   wire  [63:0] tx_axis_mac_tdata;
   wire  [7:0]  tx_axis_mac_tkeep;
   wire         tx_axis_mac_tlast;
   wire         tx_axis_mac_tuser;
   wire         tx_axis_mac_tvalid;
   wire         rx_axis_mac_tready;
   wire  [63:0] rxd_tdata;
   wire  [7:0]  rxd_tkeep;
   wire         rxd_tlast;
   wire         rxd_tvalid;
   wire  [31:0] rxs_tdata;
   wire  [3:0]  rxs_tkeep;
   wire         rxs_tlast;
   wire         rxs_tvalid;
   wire         pause_req;
   wire  [15:0] pause_val;

   int          seed = 42751;
   int          n_tx;
   int          n_rx;
   longint      total_bytes;
   bit          loaded;
   int          t_len [32];
   logic [3:0]  t_flag [32];
   logic        t_abort [32];
   logic [7:0]  t_base [32];
   int          r_len [32];
   logic [7:0]  r_base [32];
   logic        r_good [32];
   logic        r_pause [32];
   logic [15:0] r_quanta [32];
   logic [63:0] exp_tx [$];       // {data} per MAC beat
   logic [9:0]  exp_tx_ctl [$];   // {keep, last, user}
   logic [63:0] exp_rx [$];
   logic [8:0]  exp_rx_ctl [$];   // {keep, last}
   logic [32:0] exp_rxs [$];      // {last, word}
   logic [15:0] exp_pause [$];

   axi_10geth axi_10geth_inst (.*);

   initial
   begin
      mm2s_clk = 1'b0;
      forever #20 mm2s_clk = ~mm2s_clk;   // 40 ns period
   end

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Test failed");
      $fatal(1, "run stopped on first error");
   endtask

   task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
      assert (got === exp)
      else
         fail_run($sformatf("MISMATCH at %0t: %s expected %h got %h", $time, name, exp, got));
   endtask

   // Byte i of a frame with pause header and quanta overlaid in network order
   function automatic logic [7:0] frame_byte(input int i, input logic [7:0] base,
                                             input logic pause, input logic [15:0] q);
      logic [7:0] v;
      v = base + 8'(i);
      if (pause)
      begin
         case (i)
            12: v = 8'h88;
            13: v = 8'h08;
            14: v = 8'h00;
            15: v = 8'h01;
            16: v = q[15:8];
            17: v = q[7:0];
            default: v = base + 8'(i);
         endcase
      end
      return v;
   endfunction

   // Beat b of a frame with byte i on lane i mod 8
   task automatic build_beat(input int b, input int len, input logic [7:0] base, input logic pause,
                             input logic [15:0] q, output logic [63:0] d, output logic [7:0] k);
      d = 64'd0;
      k = 8'd0;
      for (int lane = 0; lane < 8; lane++)
         if (8 * b + lane < len)
         begin
            d[8*lane +: 8] = frame_byte(8 * b + lane, base, pause, q);
            k[lane]        = 1'b1;
         end
   endtask

   task automatic load_records();
      int          fd;
      int          a;
      int          b;
      int          c;
      int          d;
      int          e;
      string       tag;
      string       rest;
      logic [63:0] bd;
      logic [7:0]  bk;
      fd = $fopen("tests/axi_10geth_testdata.txt", "r");
      if (fd == 0)
         fail_run("cannot open tests/axi_10geth_testdata.txt");
      while ($fscanf(fd, "%s", tag) == 1)
      begin
         if (tag == "T" && $fscanf(fd, "%h %d %d %h", a, b, c, d) == 4)
         begin
            t_flag[n_tx]  = 4'(a);
            t_abort[n_tx] = 1'(b);
            t_len[n_tx]   = c;
            t_base[n_tx]  = 8'(d);
            for (int i = 0; i < (c + 7) / 8; i++)
            begin
               build_beat(i, c, 8'(d), 1'b0, 16'd0, bd, bk);
               exp_tx.push_back(bd);
               // tuser only on the last beat of a bad or aborted frame
               exp_tx_ctl.push_back({bk, i == (c + 7) / 8 - 1,
                  (i == (c + 7) / 8 - 1) && (a != 'hA || b != 0)});
            end
            total_bytes += c;
            n_tx++;
         end
         else if (tag == "R" && $fscanf(fd, "%d %h %d %d %h", a, b, c, d, e) == 5)
         begin
            r_len[n_rx]    = a;
            r_base[n_rx]   = 8'(b);
            r_good[n_rx]   = 1'(c);
            r_pause[n_rx]  = 1'(d);
            r_quanta[n_rx] = 16'(e);
            for (int i = 0; i < (a + 7) / 8; i++)
            begin
               build_beat(i, a, 8'(b), 1'(d), 16'(e), bd, bk);
               exp_rx.push_back(bd);
               exp_rx_ctl.push_back({bk, i == (a + 7) / 8 - 1});
            end
            exp_rxs.push_back({1'b0, 32'h5000_0000});
            exp_rxs.push_back({1'b1, 14'd0, 1'(d), 1'(c), 16'(a)});
            if (d != 0 && c != 0)
               exp_pause.push_back(16'(e));
            total_bytes += a;
            n_rx++;
         end
         else
            a = $fgets(rest, fd);   // Comment line
      end
      $fclose(fd);
      loaded = 1'b1;
   endtask

   // Ready inputs high about three quarters of the time
   initial
   begin
      logic [31:0] rnd;
      tx_axis_mac_tready = 1'b0;
      rxd_tready         = 1'b0;
      rxs_tready         = 1'b0;
      forever
      begin
         @(negedge mm2s_clk);
         rnd                = $random(seed);
         tx_axis_mac_tready = rnd[0] | rnd[1];
         rxd_tready         = rnd[2] | rnd[3];
         rxs_tready         = rnd[4] | rnd[5];
      end
   end

   // Watchdog scaled by record length
   initial
   begin
      wait (loaded);
      #(total_bytes * 8 * 40 + 20000);
      fail_run("timeout: expected traffic did not complete in time");
   end

   // Monitors sample 1 ns after the falling edge once outputs are settled
   initial
   begin
      forever
      begin
         @(negedge mm2s_clk);
         #1;
         if (rst_n && tx_axis_mac_tvalid && tx_axis_mac_tready)
         begin
            assert (exp_tx.size() > 0) else fail_run("unexpected beat on tx_axis_mac");
            check_val("tx_axis_mac_tdata", tx_axis_mac_tdata, exp_tx.pop_front());
            check_val("tx_axis_mac_tkeep/tlast/tuser",
               {tx_axis_mac_tkeep, tx_axis_mac_tlast, tx_axis_mac_tuser}, exp_tx_ctl.pop_front());
         end
         if (rst_n && rxd_tvalid && rxd_tready)
         begin
            assert (exp_rx.size() > 0) else fail_run("unexpected beat on rxd");
            check_val("rxd_tdata", rxd_tdata, exp_rx.pop_front());
            check_val("rxd_tkeep/tlast", {rxd_tkeep, rxd_tlast}, exp_rx_ctl.pop_front());
         end
         if (rst_n && rxs_tvalid && rxs_tready)
         begin
            assert (exp_rxs.size() > 0) else fail_run("unexpected word on rxs");
            check_val("rxs_tlast/tdata", {rxs_tlast, rxs_tdata}, exp_rxs.pop_front());
            check_val("rxs_tkeep", rxs_tkeep, 4'hF);
         end
         if (rst_n && pause_req)
         begin
            assert (exp_pause.size() > 0) else fail_run("pause_req pulsed for a non-pause frame");
            check_val("pause_val", pause_val, exp_pause.pop_front());
         end
      end
   end

   initial
   begin
      logic [63:0] bd;
      logic [7:0]  bk;
      logic [63:0] rd;
      logic [7:0]  rk;
      rst_n = 1'b0;
      {txc_tdata, txc_tkeep, txc_tlast, txc_tvalid} = '0;
      {txd_tdata, txd_tkeep, txd_tlast, txd_tvalid} = '0;
      {rx_axis_mac_tdata, rx_axis_mac_tkeep, rx_axis_mac_tlast} = '0;
      {rx_axis_mac_tuser, rx_axis_mac_tvalid} = '0;
      load_records();
      repeat (4) @(posedge mm2s_clk);
      @(negedge mm2s_clk);
      rst_n = 1'b1;
      #1;
      // Idle outputs right after reset
      check_val("reset valids/pause_req",
         {tx_axis_mac_tvalid, rxd_tvalid, rxs_tvalid, pause_req, txc_tready}, 5'b00001);
      check_val("pause_val", pause_val, 16'd0);
      @(negedge mm2s_clk);
      fork
         for (int f = 0; f < n_tx; f++)
         begin
            for (int w = 0; w < 2; w++)
            begin
               txc_tdata  = (w == 0) ? {t_flag[f], 28'd0} : {31'd0, t_abort[f]};
               txc_tkeep  = 4'hF;
               txc_tlast  = (w == 1);
               txc_tvalid = 1'b1;
               #1;
               while (!txc_tready)
               begin
                  @(negedge mm2s_clk);
                  #1;
               end
               @(negedge mm2s_clk);
            end
            txc_tvalid = 1'b0;
            for (int i = 0; i < (t_len[f] + 7) / 8; i++)
            begin
               build_beat(i, t_len[f], t_base[f], 1'b0, 16'd0, bd, bk);
               {txd_tdata, txd_tkeep, txd_tvalid} = {bd, bk, 1'b1};
               txd_tlast = (i == (t_len[f] + 7) / 8 - 1);
               #1;
               while (!txd_tready)
               begin
                  @(negedge mm2s_clk);
                  #1;
               end
               @(negedge mm2s_clk);
            end
            txd_tvalid = 1'b0;
         end
         for (int f = 0; f < n_rx; f++)
         begin
            for (int i = 0; i < (r_len[f] + 7) / 8; i++)
            begin
               build_beat(i, r_len[f], r_base[f], r_pause[f], r_quanta[f], rd, rk);
               {rx_axis_mac_tdata, rx_axis_mac_tkeep, rx_axis_mac_tvalid} = {rd, rk, 1'b1};
               rx_axis_mac_tlast = (i == (r_len[f] + 7) / 8 - 1);
               rx_axis_mac_tuser = rx_axis_mac_tlast && r_good[f];   // Good flag on last beat
               #1;
               while (!rx_axis_mac_tready)
               begin
                  @(negedge mm2s_clk);
                  #1;
               end
               @(negedge mm2s_clk);
            end
            rx_axis_mac_tvalid = 1'b0;
         end
      join
      while (exp_tx.size() + exp_rx.size() + exp_rxs.size() + exp_pause.size() > 0)
         @(negedge mm2s_clk);
      repeat (8) @(negedge mm2s_clk);   // Catch late duplicates
      $display("Test passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== tests/axi_10geth_testdata.txt ====
# T flag(hex) abort length(dec) base(hex)
# R length(dec) base(hex) good pause quanta(hex)
T A 0 64 10
T A 1 40 20
T 3 0 17 30
T A 0 1 40
T A 0 8 55
T A 0 9 60
T B 1 70 70
T A 0 33 f8
R 64 01 1 0 0
R 60 80 1 1 0123
R 64 90 0 1 00ff
R 5 a0 1 0 0
R 16 b0 0 0 0
R 46 c0 1 1 ffff
R 100 d0 1 0 0
R 24 e0 1 1 0042
R 1 f0 1 0 0
R 9 07 0 0 0
R 32 fe 1 1 8000
R 72 3c 1 0 0
R 18 44 1 0 0
R 40 66 0 0 0

// ==== filelist.f ====
src/eth_pkg.sv
src/eth_tx_framer.sv
src/eth_rx_payload.sv
src/eth_pause_detect.sv
src/eth_rx_status.sv
src/axi_10geth.sv
tests/axi_10geth_sva.sv
tests/tb_axi_10geth.sv

// ==== Makefile ====
# Verilator flow for the 10G bridge testbench

VERILATOR ?= verilator
TOP       ?= tb_axi_10geth
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert -j 0
PASS_MSG  ?= Test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
